//--- design/hart_pkg.sv
`default_nettype none

// shared types and constants for the four stage rv32i hart
package hart_pkg;

    // one machine word, used for data, instructions and addresses
    typedef logic [31:0] word_t;
    // index into the integer register file
    typedef logic [4:0]  reg_addr_t;
    // major opcode field, bits 6:0 of every instruction
    typedef logic [6:0]  opcode_t;

    // the only major opcodes this hart accepts
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_SYSTEM = 7'b1110011;

    // ebreak is matched on the whole word, every other system encoding traps
    localparam word_t EBREAK_INST = 32'h0010_0073;

    // there are no jumps, so the pc always moves by one instruction
    localparam word_t INST_BYTES = 32'd4;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [0:0] {
        FETCH_RUN,
        FETCH_HALTED
    } fetch_state_e;

    // everything execute needs, plus what it must carry on to retire
    typedef struct packed {
        logic      valid;
        word_t     inst;
        word_t     pc;
        reg_addr_t rs1_raddr;
        reg_addr_t rs2_raddr;
        word_t     rs1_rdata;
        word_t     rs2_rdata;
        word_t     op_a;
        word_t     op_b;
        alu_op_e   alu_op;
        reg_addr_t rd_waddr;
        logic      rd_wen;
        logic      trap;
        logic      halt;
    } dx_bundle_t;

    // the retire record, which also doubles as the register file write port
    typedef struct packed {
        logic      valid;
        word_t     inst;
        logic      trap;
        logic      halt;
        reg_addr_t rs1_raddr;
        reg_addr_t rs2_raddr;
        word_t     rs1_rdata;
        word_t     rs2_rdata;
        reg_addr_t rd_waddr;
        word_t     rd_wdata;
        word_t     pc;
        word_t     next_pc;
    } retire_t;

endpackage

`default_nettype wire

//--- design/fetch_stage.sv
`default_nettype none

// sequential instruction fetch with a one way halt
module fetch_stage #(
    parameter hart_pkg::word_t RESET_ADDR = 32'h0000_0000
) (
    input  wire             i_clk,
    input  wire             i_arst_n,
    // ebreak seen in decode this cycle
    input  wire             i_halt,
    output hart_pkg::word_t o_imem_raddr,
    // pc and valid of the word that the memory returns this cycle
    output hart_pkg::word_t o_pc,
    output logic            o_vld
);

    hart_pkg::fetch_state_e state_q;
    hart_pkg::word_t        pc_q;
    logic                   running;

    assign running = (state_q == hart_pkg::FETCH_RUN);

    // the address register is presented straight to the memory
    assign o_imem_raddr = pc_q;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= hart_pkg::FETCH_RUN;
            pc_q    <= RESET_ADDR;
            o_pc    <= RESET_ADDR;
            o_vld   <= 1'b0;
        end else begin
            // once halted the hart never leaves this state, only reset does
            if (running && i_halt) begin
                state_q <= hart_pkg::FETCH_HALTED;
            end
            if (running) begin
                pc_q <= pc_q + hart_pkg::INST_BYTES;
            end
            o_pc <= pc_q;
            // the word issued in the same cycle as the halt is already
            // behind the ebreak, so it must not be marked valid either
            o_vld <= running && !i_halt;
        end
    end

endmodule

`default_nettype wire

//--- design/register_file.sv
`default_nettype none

// 31 general purpose registers, x0 is hardwired to zero
module register_file (
    input  wire                 i_clk,
    input  wire                 i_arst_n,
    input  wire hart_pkg::reg_addr_t i_rs1_raddr,
    input  wire hart_pkg::reg_addr_t i_rs2_raddr,
    input  wire hart_pkg::reg_addr_t i_rd_waddr,
    input  wire                 i_rd_wen,
    input  wire hart_pkg::word_t     i_rd_wdata,
    output hart_pkg::word_t     o_rs1_rdata,
    output hart_pkg::word_t     o_rs2_rdata
);

    // there is no storage behind x0
    hart_pkg::word_t regs [1:31];

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd_wen && (i_rd_waddr != '0)) begin
            regs[i_rd_waddr] <= i_rd_wdata;
        end
    end

    // reads are combinational, a write in this cycle is not yet visible here
    // and decode covers that case through its writeback forwarding path
    assign o_rs1_rdata = (i_rs1_raddr == '0) ? '0 : regs[i_rs1_raddr];
    assign o_rs2_rdata = (i_rs2_raddr == '0) ? '0 : regs[i_rs2_raddr];

endmodule

`default_nettype wire

//--- design/decode_stage.sv
`default_nettype none

// decode, operand fetch with forwarding, and the decode to execute register
module decode_stage (
    input  wire                       i_clk,
    input  wire                       i_arst_n,
    input  wire                       i_vld,
    input  wire hart_pkg::word_t      i_pc,
    input  wire hart_pkg::word_t      i_inst,
    // bundle currently in execute and its alu result
    input  wire hart_pkg::dx_bundle_t i_ex_fwd,
    input  wire hart_pkg::word_t      i_ex_res,
    // record currently in writeback, which also writes the register file
    input  wire hart_pkg::retire_t    i_wb,
    output hart_pkg::dx_bundle_t      o_dx,
    output logic                      o_halt
);

    hart_pkg::opcode_t    opcode;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    hart_pkg::reg_addr_t  rs1_addr;
    hart_pkg::reg_addr_t  rs2_addr;
    hart_pkg::reg_addr_t  rd_addr;
    hart_pkg::word_t      imm_i;
    hart_pkg::word_t      imm_u;
    hart_pkg::word_t      rf_rs1;
    hart_pkg::word_t      rf_rs2;
    hart_pkg::word_t      rs1_fwd;
    hart_pkg::word_t      rs2_fwd;
    logic                 wb_wen;
    hart_pkg::alu_op_e    alu_op;
    logic                 writes_rd;
    logic                 illegal;
    hart_pkg::dx_bundle_t dx_d;

    assign opcode   = i_inst[6:0];
    assign rd_addr  = i_inst[11:7];
    assign funct3   = i_inst[14:12];
    assign rs1_addr = i_inst[19:15];
    assign rs2_addr = i_inst[24:20];
    assign funct7   = i_inst[31:25];

    // shift immediates also come out of the I format, execute uses bits 4:0
    assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
    assign imm_u = {i_inst[31:12], 12'b0};

    // execute zeroes rd when it does not write, so a nonzero rd means a write
    assign wb_wen = i_wb.valid && (i_wb.rd_waddr != '0);

    register_file regfile_i (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_rs1_raddr (rs1_addr),
        .i_rs2_raddr (rs2_addr),
        .i_rd_waddr  (i_wb.rd_waddr),
        .i_rd_wen    (wb_wen),
        .i_rd_wdata  (i_wb.rd_wdata),
        .o_rs1_rdata (rf_rs1),
        .o_rs2_rdata (rf_rs2)
    );

    // the younger producer in execute wins over the one in writeback,
    // rd_wen is already clear for x0 so it never gets forwarded
    assign rs1_fwd = (i_ex_fwd.valid && i_ex_fwd.rd_wen && (i_ex_fwd.rd_waddr == rs1_addr))
                   ? i_ex_res
                   : (wb_wen && (i_wb.rd_waddr == rs1_addr)) ? i_wb.rd_wdata : rf_rs1;
    assign rs2_fwd = (i_ex_fwd.valid && i_ex_fwd.rd_wen && (i_ex_fwd.rd_waddr == rs2_addr))
                   ? i_ex_res
                   : (wb_wen && (i_wb.rd_waddr == rs2_addr)) ? i_wb.rd_wdata : rf_rs2;

    assign o_halt = i_vld && (i_inst == hart_pkg::EBREAK_INST);

    always_comb begin
        alu_op    = hart_pkg::ALU_ADD;
        writes_rd = 1'b1;
        illegal   = 1'b0;
        case (opcode)
            hart_pkg::OPC_OP: begin
                case ({funct7, funct3})
                    10'b0000000_000: alu_op = hart_pkg::ALU_ADD;
                    10'b0100000_000: alu_op = hart_pkg::ALU_SUB;
                    10'b0000000_001: alu_op = hart_pkg::ALU_SLL;
                    10'b0000000_010: alu_op = hart_pkg::ALU_SLT;
                    10'b0000000_011: alu_op = hart_pkg::ALU_SLTU;
                    10'b0000000_100: alu_op = hart_pkg::ALU_XOR;
                    10'b0000000_101: alu_op = hart_pkg::ALU_SRL;
                    10'b0100000_101: alu_op = hart_pkg::ALU_SRA;
                    10'b0000000_110: alu_op = hart_pkg::ALU_OR;
                    10'b0000000_111: alu_op = hart_pkg::ALU_AND;
                    default:         illegal = 1'b1;
                endcase
            end
            hart_pkg::OPC_OP_IMM: begin
                case (funct3)
                    3'b000: alu_op = hart_pkg::ALU_ADD;
                    3'b010: alu_op = hart_pkg::ALU_SLT;
                    3'b011: alu_op = hart_pkg::ALU_SLTU;
                    3'b100: alu_op = hart_pkg::ALU_XOR;
                    3'b110: alu_op = hart_pkg::ALU_OR;
                    3'b111: alu_op = hart_pkg::ALU_AND;
                    // immediate shifts reuse funct7 to tell srai from srli
                    3'b001: begin
                        alu_op  = hart_pkg::ALU_SLL;
                        illegal = (funct7 != 7'b0000000);
                    end
                    default: begin
                        alu_op  = funct7[5] ? hart_pkg::ALU_SRA : hart_pkg::ALU_SRL;
                        illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                    end
                endcase
            end
            hart_pkg::OPC_LUI:   alu_op = hart_pkg::ALU_PASS_B;
            hart_pkg::OPC_AUIPC: alu_op = hart_pkg::ALU_ADD;
            hart_pkg::OPC_SYSTEM: begin
                // ebreak halts and writes nothing, anything else here traps
                writes_rd = 1'b0;
                illegal   = (i_inst != hart_pkg::EBREAK_INST);
            end
            default: illegal = 1'b1;
        endcase
    end

    always_comb begin
        dx_d.valid     = i_vld;
        dx_d.inst      = i_inst;
        dx_d.pc        = i_pc;
        dx_d.rs1_raddr = rs1_addr;
        dx_d.rs2_raddr = rs2_addr;
        dx_d.rs1_rdata = rs1_fwd;
        dx_d.rs2_rdata = rs2_fwd;
        // auipc adds to the pc, lui ignores operand a altogether
        dx_d.op_a      = (opcode == hart_pkg::OPC_AUIPC) ? i_pc : rs1_fwd;
        dx_d.op_b      = (opcode == hart_pkg::OPC_OP) ? rs2_fwd
                       : ((opcode == hart_pkg::OPC_LUI) || (opcode == hart_pkg::OPC_AUIPC))
                       ? imm_u : imm_i;
        dx_d.alu_op    = alu_op;
        dx_d.rd_waddr  = rd_addr;
        dx_d.rd_wen    = i_vld && writes_rd && !illegal && (rd_addr != '0);
        // trap and halt are only raised for real instructions, never bubbles
        dx_d.trap      = i_vld && illegal;
        dx_d.halt      = o_halt;
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_dx <= '0;
        end else begin
            o_dx <= dx_d;
        end
    end

endmodule

`default_nettype wire

//--- design/execute_stage.sv
`default_nettype none

// alu and the execute to writeback register holding the retire record
module execute_stage (
    input  wire                       i_clk,
    input  wire                       i_arst_n,
    input  wire hart_pkg::dx_bundle_t i_dx,
    // combinational result, also forwarded back to decode
    output hart_pkg::word_t           o_res,
    output hart_pkg::retire_t         o_wb
);

    hart_pkg::opcode_t opcode;
    logic [4:0]        shamt;
    logic              lt_s;
    logic              lt_u;
    logic              reads_rs1;
    logic              reads_rs2;
    hart_pkg::retire_t wb_d;

    assign opcode = i_dx.inst[6:0];
    assign shamt  = i_dx.op_b[4:0];
    assign lt_s   = $signed(i_dx.op_a) < $signed(i_dx.op_b);
    assign lt_u   = i_dx.op_a < i_dx.op_b;

    always_comb begin
        case (i_dx.alu_op)
            hart_pkg::ALU_ADD:    o_res = i_dx.op_a + i_dx.op_b;
            hart_pkg::ALU_SUB:    o_res = i_dx.op_a - i_dx.op_b;
            hart_pkg::ALU_SLL:    o_res = i_dx.op_a << shamt;
            hart_pkg::ALU_SLT:    o_res = {31'b0, lt_s};
            hart_pkg::ALU_SLTU:   o_res = {31'b0, lt_u};
            hart_pkg::ALU_XOR:    o_res = i_dx.op_a ^ i_dx.op_b;
            hart_pkg::ALU_SRL:    o_res = i_dx.op_a >> shamt;
            hart_pkg::ALU_SRA:    o_res = $signed(i_dx.op_a) >>> shamt;
            hart_pkg::ALU_OR:     o_res = i_dx.op_a | i_dx.op_b;
            hart_pkg::ALU_AND:    o_res = i_dx.op_a & i_dx.op_b;
            hart_pkg::ALU_PASS_B: o_res = i_dx.op_b;
            default:              o_res = '0;
        endcase
    end

    // only register and immediate arithmetic read sources, and only
    // the register form reads rs2; a trapped word reads nothing
    assign reads_rs1 = !i_dx.trap
                     && ((opcode == hart_pkg::OPC_OP) || (opcode == hart_pkg::OPC_OP_IMM));
    assign reads_rs2 = !i_dx.trap && (opcode == hart_pkg::OPC_OP);

    always_comb begin
        wb_d.valid     = i_dx.valid;
        wb_d.inst      = i_dx.inst;
        wb_d.trap      = i_dx.trap;
        wb_d.halt      = i_dx.halt;
        wb_d.rs1_raddr = reads_rs1 ? i_dx.rs1_raddr : '0;
        wb_d.rs2_raddr = reads_rs2 ? i_dx.rs2_raddr : '0;
        wb_d.rs1_rdata = reads_rs1 ? i_dx.rs1_rdata : '0;
        wb_d.rs2_rdata = reads_rs2 ? i_dx.rs2_rdata : '0;
        // a zero rd here tells the register file there is nothing to write
        wb_d.rd_waddr  = i_dx.rd_wen ? i_dx.rd_waddr : '0;
        wb_d.rd_wdata  = i_dx.rd_wen ? o_res : '0;
        wb_d.pc        = i_dx.pc;
        wb_d.next_pc   = i_dx.pc + hart_pkg::INST_BYTES;
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_wb <= '0;
        end else begin
            o_wb <= wb_d;
        end
    end

endmodule

`default_nettype wire

//--- design/hart.sv
`default_nettype none

// four stage in-order rv32i hart: fetch, decode, execute, writeback
module hart #(
    // first instruction address after reset
    parameter hart_pkg::word_t RESET_ADDR = 32'h0000_0000
) (
    input  wire                     i_clk,
    input  wire                     i_arst_n,
    output hart_pkg::word_t         o_imem_raddr,
    // word for the address issued one cycle earlier
    input  wire hart_pkg::word_t    i_imem_rdata,
    output logic                    o_retire_valid,
    output hart_pkg::word_t         o_retire_inst,
    output logic                    o_retire_trap,
    output logic                    o_retire_halt,
    output hart_pkg::reg_addr_t     o_retire_rs1_raddr,
    output hart_pkg::reg_addr_t     o_retire_rs2_raddr,
    output hart_pkg::word_t         o_retire_rs1_rdata,
    output hart_pkg::word_t         o_retire_rs2_rdata,
    output hart_pkg::reg_addr_t     o_retire_rd_waddr,
    output hart_pkg::word_t         o_retire_rd_wdata,
    output hart_pkg::word_t         o_retire_pc,
    output hart_pkg::word_t         o_retire_next_pc
);

    // fetch to decode
    hart_pkg::word_t      fe_pc;
    logic                 fe_vld;
    // decode to fetch, and decode to execute
    logic                 de_halt;
    hart_pkg::dx_bundle_t dx;
    // execute result, and the record sitting in writeback
    hart_pkg::word_t      ex_res;
    hart_pkg::retire_t    wb;

    fetch_stage #(
        .RESET_ADDR (RESET_ADDR)
    ) fetch_i (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_halt       (de_halt),
        .o_imem_raddr (o_imem_raddr),
        .o_pc         (fe_pc),
        .o_vld        (fe_vld)
    );

    // the instruction word comes straight from memory, not through fetch
    decode_stage decode_i (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_vld    (fe_vld),
        .i_pc     (fe_pc),
        .i_inst   (i_imem_rdata),
        .i_ex_fwd (dx),
        .i_ex_res (ex_res),
        .i_wb     (wb),
        .o_dx     (dx),
        .o_halt   (de_halt)
    );

    execute_stage execute_i (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_dx     (dx),
        .o_res    (ex_res),
        .o_wb     (wb)
    );

    // the writeback record is the retire report
    assign o_retire_valid     = wb.valid;
    assign o_retire_inst      = wb.inst;
    assign o_retire_trap      = wb.trap;
    assign o_retire_halt      = wb.halt;
    assign o_retire_rs1_raddr = wb.rs1_raddr;
    assign o_retire_rs2_raddr = wb.rs2_raddr;
    assign o_retire_rs1_rdata = wb.rs1_rdata;
    assign o_retire_rs2_rdata = wb.rs2_rdata;
    assign o_retire_rd_waddr  = wb.rd_waddr;
    assign o_retire_rd_wdata  = wb.rd_wdata;
    assign o_retire_pc        = wb.pc;
    assign o_retire_next_pc   = wb.next_pc;

endmodule

`default_nettype wire

//--- verification/hart_tb.sv
`default_nettype none

// testbench for the hart. it runs the directed program from the stimulus file,
// then a few random op-imm fillers and a closing ebreak, and checks every retire
module hart_tb;

    timeunit 1ns;
    timeprecision 1ps;

    // the auipc results in the stimulus file assume this start address
    localparam hart_pkg::word_t RESET_ADDR = 32'h0000_0100;
    localparam int MAX_FILE     = 48;
    localparam int NUM_FILL     = 6;
    localparam int MAX_PROG     = MAX_FILE + NUM_FILL + 1;
    localparam int QUIET_CYCLES = 10;
    // funct3 codes a filler may use, for addi, slti, sltiu, xori, ori and andi
    localparam logic [17:0] FILL_F3 = {3'd7, 3'd6, 3'd4, 3'd3, 3'd2, 3'd0};

    logic                i_clk;
    logic                i_arst_n;
    hart_pkg::word_t     i_imem_rdata;
    hart_pkg::word_t     o_imem_raddr;
    logic                o_retire_valid;
    hart_pkg::word_t     o_retire_inst;
    logic                o_retire_trap;
    logic                o_retire_halt;
    hart_pkg::reg_addr_t o_retire_rs1_raddr;
    hart_pkg::reg_addr_t o_retire_rs2_raddr;
    hart_pkg::word_t     o_retire_rs1_rdata;
    hart_pkg::word_t     o_retire_rs2_rdata;
    hart_pkg::reg_addr_t o_retire_rd_waddr;
    hart_pkg::word_t     o_retire_rd_wdata;
    hart_pkg::word_t     o_retire_pc;
    hart_pkg::word_t     o_retire_next_pc;

    // each directed instruction takes three words, the encoding, rd address and rd data
    logic [31:0]         stim [0:3*MAX_FILE-1];
    hart_pkg::word_t     prog_word [0:MAX_PROG-1];
    hart_pkg::reg_addr_t prog_rd [0:MAX_PROG-1];
    hart_pkg::word_t     prog_data [0:MAX_PROG-1];
    logic                prog_fill [0:MAX_PROG-1];
    int                  prog_len;
    // architectural register state as the program should leave it
    hart_pkg::word_t     model [0:31];
    hart_pkg::word_t     imem_q;
    int                  cycle_cnt;
    int                  timeout_cycles;
    integer              seed;

    hart #(
        .RESET_ADDR (RESET_ADDR)
    ) dut_i (
        .i_clk              (i_clk),
        .i_arst_n           (i_arst_n),
        .o_imem_raddr       (o_imem_raddr),
        .i_imem_rdata       (i_imem_rdata),
        .o_retire_valid     (o_retire_valid),
        .o_retire_inst      (o_retire_inst),
        .o_retire_trap      (o_retire_trap),
        .o_retire_halt      (o_retire_halt),
        .o_retire_rs1_raddr (o_retire_rs1_raddr),
        .o_retire_rs2_raddr (o_retire_rs2_raddr),
        .o_retire_rs1_rdata (o_retire_rs1_rdata),
        .o_retire_rs2_rdata (o_retire_rs2_rdata),
        .o_retire_rd_waddr  (o_retire_rd_waddr),
        .o_retire_rd_wdata  (o_retire_rd_wdata),
        .o_retire_pc        (o_retire_pc),
        .o_retire_next_pc   (o_retire_next_pc)
    );

    initial begin
        i_clk = 1'b0;
        forever begin
            #10 i_clk = ~i_clk;
        end
    end

    function automatic hart_pkg::word_t imem_word(input hart_pkg::word_t addr);
        hart_pkg::word_t offset;
        offset = addr - RESET_ADDR;
        if ((addr >= RESET_ADDR) && ((offset >> 2) < prog_len) && (offset[1:0] == 2'b00)) begin
            return prog_word[offset >> 2];
        end
        // outside the program every address reads back as its own inverse
        return ~addr;
    endfunction

    // synchronous memory that takes the address at the rising edge and drives data at the falling edge
    always @(posedge i_clk) begin
        imem_q <= imem_word(o_imem_raddr);
    end

    always @(negedge i_clk) begin
        i_imem_rdata <= imem_q;
    end

    // cycle 0 is the first cycle after reset lets go
    always @(posedge i_clk) begin
        if (i_arst_n) begin
            cycle_cnt <= cycle_cnt + 1;
            if (cycle_cnt >= timeout_cycles) begin
                $display("timeout: the program did not finish within %0d cycles", timeout_cycles);
                $display("TEST FAILED");
                $fatal(1);
            end
        end
    end

    // legal encodings by the rv32i base rules, limited to what this hart runs
    function automatic logic is_legal(input hart_pkg::word_t w);
        case (w[6:0])
            hart_pkg::OPC_OP: begin
                return (w[31:25] == 7'h00)
                    || ((w[31:25] == 7'h20) && ((w[14:12] == 3'd0) || (w[14:12] == 3'd5)));
            end
            hart_pkg::OPC_OP_IMM: begin
                if (w[14:12] == 3'd1) begin
                    return w[31:25] == 7'h00;
                end
                if (w[14:12] == 3'd5) begin
                    return (w[31:25] == 7'h00) || (w[31:25] == 7'h20);
                end
                return 1'b1;
            end
            hart_pkg::OPC_LUI, hart_pkg::OPC_AUIPC: return 1'b1;
            default: return w == hart_pkg::EBREAK_INST;
        endcase
    endfunction

    // result of a non-shift op-imm instruction, immediate sign extended
    function automatic hart_pkg::word_t op_imm_result(input logic [2:0] f3,
                                                      input hart_pkg::word_t a,
                                                      input logic [11:0] imm12);
        hart_pkg::word_t b;
        b = {{20{imm12[11]}}, imm12};
        case (f3)
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd6: return a | b;
            3'd7: return a & b;
            default: return a + b;
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic build_program();
        int                  n_file;
        int                  pick;
        logic [11:0]         imm12;
        hart_pkg::reg_addr_t rs1;
        hart_pkg::reg_addr_t rd;
        $readmemh("verification/hart_stimulus.hex", stim);
        n_file = 0;
        while ((n_file < MAX_FILE) && !$isunknown(stim[3*n_file])) begin
            prog_word[n_file] = stim[3*n_file];
            prog_rd[n_file]   = stim[3*n_file+1][4:0];
            prog_data[n_file] = stim[3*n_file+2];
            prog_fill[n_file] = 1'b0;
            n_file++;
        end
        if (n_file == 0) begin
            $display("the stimulus file could not be read or holds no instructions");
            $display("TEST FAILED");
            $fatal(1);
        end
        prog_len = n_file;
        // fillers write x1..x31 and read any register, their results come from the model
        for (int i = 0; i < NUM_FILL; i++) begin
            imm12 = 12'($random(seed));
            rs1   = 5'($random(seed));
            rd    = 5'(1 + ($unsigned($random(seed)) % 31));
            pick  = $unsigned($random(seed)) % 6;
            prog_word[prog_len] = {imm12, rs1, FILL_F3[3*pick +: 3], rd, hart_pkg::OPC_OP_IMM};
            prog_rd[prog_len]   = rd;
            prog_data[prog_len] = '0;
            prog_fill[prog_len] = 1'b1;
            prog_len++;
        end
        // the program always ends with ebreak, which writes nothing
        prog_word[prog_len] = hart_pkg::EBREAK_INST;
        prog_rd[prog_len]   = '0;
        prog_data[prog_len] = '0;
        prog_fill[prog_len] = 1'b0;
        prog_len++;
    endtask

    task automatic check_retire(input int k);
        hart_pkg::word_t     w;
        hart_pkg::word_t     pc;
        logic                legal;
        hart_pkg::reg_addr_t rs1;
        hart_pkg::reg_addr_t rs2;
        hart_pkg::word_t     exp_data;
        w     = prog_word[k];
        pc    = RESET_ADDR + 32'(4 * k);
        legal = is_legal(w);
        // only op reads both sources and op-imm reads rs1, a trap reads nothing
        rs1 = (legal && ((w[6:0] == hart_pkg::OPC_OP) || (w[6:0] == hart_pkg::OPC_OP_IMM)))
            ? w[19:15] : '0;
        rs2 = (legal && (w[6:0] == hart_pkg::OPC_OP)) ? w[24:20] : '0;
        exp_data = prog_fill[k] ? op_imm_result(w[14:12], model[w[19:15]], w[31:20])
                                : prog_data[k];
        compare_value("o_retire_inst", o_retire_inst, w);
        compare_value("o_retire_pc", o_retire_pc, pc);
        compare_value("o_retire_next_pc", o_retire_next_pc, pc + 32'd4);
        compare_value("o_retire_trap", o_retire_trap, !legal);
        compare_value("o_retire_halt", o_retire_halt, w == hart_pkg::EBREAK_INST);
        compare_value("o_retire_rs1_raddr", o_retire_rs1_raddr, rs1);
        compare_value("o_retire_rs2_raddr", o_retire_rs2_raddr, rs2);
        compare_value("o_retire_rs1_rdata", o_retire_rs1_rdata, model[rs1]);
        compare_value("o_retire_rs2_rdata", o_retire_rs2_rdata, model[rs2]);
        compare_value("o_retire_rd_waddr", o_retire_rd_waddr, prog_rd[k]);
        compare_value("o_retire_rd_wdata", o_retire_rd_wdata, exp_data);
        if (prog_rd[k] != '0) begin
            model[prog_rd[k]] = exp_data;
        end
    endtask

    initial begin
        seed         = 81702;
        i_arst_n     = 1'b0;
        i_imem_rdata = '0;
        cycle_cnt    = 0;
        for (int r = 0; r < 32; r++) begin
            model[r] = '0;
        end
        build_program();
        timeout_cycles = prog_len + 20;
        repeat (8) @(negedge i_clk);
        i_arst_n = 1'b1;
        // the first fetch goes out in the cycle that reset is released
        compare_value("o_imem_raddr", o_imem_raddr, RESET_ADDR);
        compare_value("o_retire_valid", o_retire_valid, 1'b0);
        for (int k = 0; k < prog_len; k++) begin
            @(negedge i_clk);
            while (o_retire_valid !== 1'b1) begin
                @(negedge i_clk);
            end
            // no stalls, so instruction k retires exactly three cycles after its fetch
            compare_value("o_retire_valid cycle", cycle_cnt, 3 + k);
            check_retire(k);
        end
        // after the ebreak nothing else may retire
        repeat (QUIET_CYCLES) begin
            @(negedge i_clk);
            compare_value("o_retire_valid", o_retire_valid, 1'b0);
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/hart_stimulus.hex
// columns: instruction word, expected rd address, expected rd data (zero when rd is not written)
// the program is loaded at 0x100, which the auipc result depends on
00500093 01 00000005 // addi x1, x0, 5
ffd00113 02 fffffffd // addi x2, x0, -3
002081b3 03 00000002 // add x3, x1, x2
40118233 04 fffffffd // sub x4, x3, x1
001222b3 05 00000001 // slt x5, x4, x1
00123333 06 00000000 // sltu x6, x4, x1
123453b7 07 12345000 // lui x7, 0x12345
67838393 07 12345678 // addi x7, x7, 0x678
0023c433 08 edcba985 // xor x8, x7, x2
40445493 09 fedcba98 // srai x9, x8, 4
00445513 0a 0edcba98 // srli x10, x8, 4
00309593 0b 00000028 // slli x11, x1, 3
00139633 0c 468acf00 // sll x12, x7, x1
001456b3 0d 076e5d4c // srl x13, x8, x1
40145733 0e ff6e5d4c // sra x14, x8, x1
00b2e7b3 0f 00000029 // or x15, x5, x11
00957833 10 0edcba98 // and x16, x10, x9
00001897 11 00001144 // auipc x17, 0x1
00708013 00 00000000 // addi x0, x1, 7
00100933 12 00000005 // add x18, x0, x1
021089b3 00 00000000 // mul x19, x1, x1 traps
00198a13 14 00000001 // addi x20, x19, 1
fff12a93 15 00000001 // slti x21, x2, -1
fff0bb13 16 00000001 // sltiu x22, x1, -1
fff0cb93 17 fffffffa // xori x23, x1, -1
ffffffff 00 00000000 // illegal opcode traps

//--- project.f
design/hart_pkg.sv
design/fetch_stage.sv
design/register_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/hart.sv
verification/hart_tb.sv

//--- Bender.yml
package:
  name: hart

sources:
  # package first, then the stages, then the top level
  - design/hart_pkg.sv
  - design/fetch_stage.sv
  - design/register_file.sv
  - design/decode_stage.sv
  - design/execute_stage.sv
  - design/hart.sv
  - target: test
    files:
      - verification/hart_tb.sv
